// ==== ex_mem_wb_pipe.f ====
src/pipe_pkg.sv
src/ex_mem_prep.sv
src/ex_mem_reg.sv
src/mem_wb_stage.sv
src/ex_mem_wb_pipe.sv
dv/tb_ex_mem_wb_pipe.sv

// ==== Bender.yml ====
package:
  name: ex_mem_wb_pipe

sources:
  - files:
      - src/pipe_pkg.sv
      - src/ex_mem_prep.sv
      - src/ex_mem_reg.sv
      - src/mem_wb_stage.sv
      - src/ex_mem_wb_pipe.sv
  - target: test
    files:
      - dv/tb_ex_mem_wb_pipe.sv

export_include_dirs: []

dependencies: {}

frozen: false

// ==== dv/tb_ex_mem_wb_pipe.sv ====
module tb_ex_mem_wb_pipe;
    timeunit 1ns;
    timeprecision 1ps;

    import pipe_pkg::*;

    localparam int NUM_TESTS      = 400;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_TESTS + 1) + 50;

    logic      clk;
    logic      rst;
    logic      ex_mem_ld;
    ex_op_t    ex_op;
    word_t     dmem_rdata;
    logic      mem_wb_ld;
    logic      wb_fwd_ld;
    word_t     wb_fwd_data;
    dmem_req_t dmem_req;
    word_t     exe_fwd_data;
    logic      ex_mem_valid;
    word_t     mem_fwd_data;
    wb_info_t  wb_info;
    logic      mem_wb_valid;
    word_t     wb_fwd_out;

    integer seed = 32'haac0_8aec;
    int     cycles;
    int     word_errs;
    int     be_errs;
    int     req_errs;
    int     info_errs;
    int     bit_errs;

    // reference state
    word_t       exp_fwd;
    dmem_req_t   exp_req;
    memfwd_sel_e exp_memfwd_sel;
    wb_info_t    exp_tag;       // rd and ld_reg held in ex/mem
    logic        exp_ex_valid;
    word_t       exp_mem_fwd;
    wb_info_t    exp_info;
    logic        exp_mem_valid;
    word_t       exp_wb_fwd;

    ex_mem_wb_pipe i_dut (
        .clk            (clk),
        .rst            (rst),
        .ex_mem_ld_i    (ex_mem_ld),
        .ex_op_i        (ex_op),
        .dmem_rdata_i   (dmem_rdata),
        .mem_wb_ld_i    (mem_wb_ld),
        .wb_fwd_ld_i    (wb_fwd_ld),
        .wb_fwd_data_i  (wb_fwd_data),
        .dmem_req_o     (dmem_req),
        .exe_fwd_data_o (exe_fwd_data),
        .ex_mem_valid_o (ex_mem_valid),
        .mem_fwd_data_o (mem_fwd_data),
        .wb_info_o      (wb_info),
        .mem_wb_valid_o (mem_wb_valid),
        .wb_fwd_data_o  (wb_fwd_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string format_req(input dmem_req_t req);
        return $sformatf("addr %h wdata %h be %b rd %b wr %b",
                         req.addr, req.wdata, req.byte_en, req.read, req.write);
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            word_errs++;
            $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_be(input string name, input byte_en_t exp, input byte_en_t act);
        if (act !== exp) begin
            be_errs++;
            $display("FAILED %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_req(input string name, input dmem_req_t exp, input dmem_req_t act);
        if (act !== exp) begin
            req_errs++;
            $display("FAILED %0t %s expected %s actual %s",
                     $time, name, format_req(exp), format_req(act));
        end
    endtask

    task automatic check_info(input string name, input wb_info_t exp, input wb_info_t act);
        if (act !== exp) begin
            info_errs++;
            $display("FAILED %0t %s expected rd %0d ld_reg %b actual rd %0d ld_reg %b",
                     $time, name, exp.rd, exp.ld_reg, act.rd, act.ld_reg);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            bit_errs++;
            $display("FAILED %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // access width in bytes from funct3 or 0 for an undefined code
    function automatic int access_bytes(input logic [2:0] f3);
        case (f3)
            3'd0, 3'd4: return 1;
            3'd1, 3'd5: return 2;
            3'd2:       return 4;
            default:    return 0;
        endcase
    endfunction

    task automatic update_model();
        word_t      src;
        int         nbytes;
        logic [7:0] wide_mask;
        // mem/wb first so it sees the old ex/mem contents
        if (mem_wb_ld) begin
            exp_mem_fwd   = (exp_memfwd_sel == memfwd_exe_fwd) ? exp_fwd : dmem_rdata;
            exp_info      = exp_tag;
            exp_mem_valid = 1'b1;
        end
        if (wb_fwd_ld) begin
            exp_wb_fwd = wb_fwd_data;
        end
        if (ex_mem_ld) begin
            case (ex_op.ctrl.exefwd_sel)
                exefwd_br_en_zext: exp_fwd = word_t'(ex_op.br_en);
                exefwd_u_imm:      exp_fwd = ex_op.u_imm;
                default:           exp_fwd = ex_op.alu_out;
            endcase
            exp_req.read   = ex_op.ctrl.mem_read;
            exp_req.write  = ex_op.ctrl.mem_write;
            exp_memfwd_sel = ex_op.ctrl.memfwd_sel;
            exp_tag.rd     = ex_op.ctrl.rd;
            exp_tag.ld_reg = ex_op.ctrl.ld_reg;
            exp_ex_valid   = 1'b1;
            if (ex_op.ctrl.mem_read || ex_op.ctrl.mem_write) begin
                src = (ex_op.ctrl.mar_sel == mar_alu_out) ? ex_op.alu_out : ex_op.pc;
                if (ex_op.ctrl.mem_read) begin
                    nbytes = access_bytes(ex_op.ctrl.load_funct3);
                end else begin
                    nbytes = access_bytes(ex_op.ctrl.store_funct3);
                    if (ex_op.ctrl.store_funct3[2]) nbytes = 0; // no unsigned stores
                end
                wide_mask = ((8'd1 << nbytes) - 8'd1) << src[1:0];
                if (nbytes == 4) begin
                    exp_req.byte_en = 4'b1111;
                    exp_req.addr    = src;
                end else if (nbytes == 0) begin
                    exp_req.byte_en = 4'b0000;
                    exp_req.addr    = src;
                end else begin
                    exp_req.byte_en = wide_mask[3:0];
                    exp_req.addr    = {src[31:2], 2'b00};
                end
                exp_req.wdata = ex_op.rs2_data;
            end
        end
    endtask

    task automatic drive_random();
        ex_op_t      op;
        logic [31:0] r;
        op.alu_out  = $random(seed);
        op.u_imm    = $random(seed);
        op.rs2_data = $random(seed);
        op.pc       = $random(seed);
        r = $random(seed);
        op.br_en             = r[0];
        op.ctrl.mar_sel      = mar_sel_e'(r[1]);
        op.ctrl.memfwd_sel   = memfwd_sel_e'(r[2]);
        op.ctrl.mem_read     = r[3];
        op.ctrl.mem_write    = r[4];
        op.ctrl.load_funct3  = load_funct3_e'(r[7:5]);   // undefined codes too
        op.ctrl.store_funct3 = store_funct3_e'(r[10:8]);
        op.ctrl.rd           = r[15:11];
        op.ctrl.ld_reg       = r[16];
        op.ctrl.exefwd_sel   = exefwd_sel_e'(2'($unsigned($random(seed)) % 32'd3));
        ex_op <= op;
        r = $random(seed);
        ex_mem_ld   <= (r[1:0] != 2'b00);
        mem_wb_ld   <= (r[3:2] != 2'b00);
        wb_fwd_ld   <= r[4];
        dmem_rdata  <= $random(seed);
        wb_fwd_data <= $random(seed);
    endtask

    task automatic check_outputs();
        check_word("exe_fwd_data_o", exp_fwd, exe_fwd_data);
        check_req("dmem_req_o", exp_req, dmem_req);
        check_be("dmem_req_o.byte_en", exp_req.byte_en, dmem_req.byte_en);
        check_bit("ex_mem_valid_o", exp_ex_valid, ex_mem_valid);
        check_word("mem_fwd_data_o", exp_mem_fwd, mem_fwd_data);
        check_info("wb_info_o", exp_info, wb_info);
        check_bit("mem_wb_valid_o", exp_mem_valid, mem_wb_valid);
        check_word("wb_fwd_data_o", exp_wb_fwd, wb_fwd_out);
    endtask

    initial begin
        int total;
        rst         = 1'b1;
        ex_mem_ld   = 1'b0;
        ex_op       = '0;
        dmem_rdata  = '0;
        mem_wb_ld   = 1'b0;
        wb_fwd_ld   = 1'b0;
        wb_fwd_data = '0;
        exp_fwd        = '0;
        exp_req        = '0;
        exp_memfwd_sel = memfwd_mem_rdata;
        exp_tag        = '0;
        exp_ex_valid   = 1'b0;
        exp_mem_fwd    = '0;
        exp_info       = '0;
        exp_mem_valid  = 1'b0;
        exp_wb_fwd     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs(); // everything zero out of reset
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            update_model();
            drive_random();
            @(negedge clk);
            check_outputs();
        end
        total = word_errs + be_errs + req_errs + info_errs + bit_errs;
        $display("errors: word %0d byte_en %0d request %0d wb_info %0d flag %0d total %0d",
                 word_errs, be_errs, req_errs, info_errs, bit_errs, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_ex_mem_wb_pipe

// ==== src/ex_mem_wb_pipe.sv ====
module ex_mem_wb_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_mem_ld_i,
    input  pipe_pkg::ex_op_t    ex_op_i,
    input  pipe_pkg::word_t     dmem_rdata_i,
    input  logic                mem_wb_ld_i,
    input  logic                wb_fwd_ld_i,
    input  pipe_pkg::word_t     wb_fwd_data_i,
    output pipe_pkg::dmem_req_t dmem_req_o,
    output pipe_pkg::word_t     exe_fwd_data_o,
    output logic                ex_mem_valid_o,
    output pipe_pkg::word_t     mem_fwd_data_o,
    output pipe_pkg::wb_info_t  wb_info_o,
    output logic                mem_wb_valid_o,
    output pipe_pkg::word_t     wb_fwd_data_o
);
    import pipe_pkg::*;

    ex_mem_t prep;  // combinational execute result
    ex_mem_t stage; // registered ex/mem state

    ex_mem_prep i_ex_mem_prep (
        .ex_op_i (ex_op_i),
        .prep_o  (prep)
    );

    ex_mem_reg i_ex_mem_reg (
        .clk            (clk),
        .rst            (rst),
        .ex_mem_ld_i    (ex_mem_ld_i),
        .prep_i         (prep),
        .stage_o        (stage),
        .dmem_req_o     (dmem_req_o),
        .exe_fwd_data_o (exe_fwd_data_o),
        .ex_mem_valid_o (ex_mem_valid_o)
    );

    mem_wb_stage i_mem_wb_stage (
        .clk            (clk),
        .rst            (rst),
        .mem_wb_ld_i    (mem_wb_ld_i),
        .stage_i        (stage),
        .dmem_rdata_i   (dmem_rdata_i),
        .wb_fwd_ld_i    (wb_fwd_ld_i),
        .wb_fwd_data_i  (wb_fwd_data_i),
        .mem_fwd_data_o (mem_fwd_data_o),
        .wb_info_o      (wb_info_o),
        .mem_wb_valid_o (mem_wb_valid_o),
        .wb_fwd_data_o  (wb_fwd_data_o)
    );

endmodule : ex_mem_wb_pipe

// ==== src/mem_wb_stage.sv ====
module mem_wb_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_wb_ld_i,
    input  pipe_pkg::ex_mem_t  stage_i,
    input  pipe_pkg::word_t    dmem_rdata_i,
    input  logic               wb_fwd_ld_i,
    input  pipe_pkg::word_t    wb_fwd_data_i,
    output pipe_pkg::word_t    mem_fwd_data_o,
    output pipe_pkg::wb_info_t wb_info_o,
    output logic               mem_wb_valid_o,
    output pipe_pkg::word_t    wb_fwd_data_o
);
    import pipe_pkg::*;

    word_t    fwd_sel;
    word_t    mem_fwd_q;
    wb_info_t wb_info_q;
    logic     valid_q;
    word_t    wb_fwd_q;

    always_comb begin
        case (stage_i.memfwd_sel)
            memfwd_mem_rdata: fwd_sel = dmem_rdata_i;
            memfwd_exe_fwd:   fwd_sel = stage_i.fwd_data;
            default:          fwd_sel = stage_i.fwd_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_fwd_q        <= '0;
            wb_info_q.rd     <= '0;
            wb_info_q.ld_reg <= 1'b0;
        end else if (mem_wb_ld_i) begin
            mem_fwd_q        <= fwd_sel;
            wb_info_q.rd     <= stage_i.rd;
            wb_info_q.ld_reg <= stage_i.ld_reg;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (mem_wb_ld_i) begin
            valid_q <= 1'b1;
        end
    end

    // writeback forward value loaded on its own strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_fwd_q <= '0;
        end else if (wb_fwd_ld_i) begin
            wb_fwd_q <= wb_fwd_data_i;
        end
    end

    assign mem_fwd_data_o = mem_fwd_q;
    assign wb_info_o      = wb_info_q;
    assign mem_wb_valid_o = valid_q;
    assign wb_fwd_data_o  = wb_fwd_q;

endmodule : mem_wb_stage

// ==== src/ex_mem_reg.sv ====
module ex_mem_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_mem_ld_i,
    input  pipe_pkg::ex_mem_t   prep_i,
    output pipe_pkg::ex_mem_t   stage_o,
    output pipe_pkg::dmem_req_t dmem_req_o,
    output pipe_pkg::word_t     exe_fwd_data_o,
    output logic                ex_mem_valid_o
);
    import pipe_pkg::*;

    ex_mem_t stage_q;
    logic    valid_q;
    logic    req_ld;

    assign req_ld = ex_mem_ld_i & prep_i.mem_access;

    // fields that follow every load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_q.fwd_data   <= '0;
            stage_q.mem_access <= 1'b0;
            stage_q.mem_read   <= 1'b0;
            stage_q.mem_write  <= 1'b0;
            stage_q.memfwd_sel <= memfwd_mem_rdata;
            stage_q.rd         <= '0;
            stage_q.ld_reg     <= 1'b0;
        end else if (ex_mem_ld_i) begin
            stage_q.fwd_data   <= prep_i.fwd_data;
            stage_q.mem_access <= prep_i.mem_access;
            stage_q.mem_read   <= prep_i.mem_read;
            stage_q.mem_write  <= prep_i.mem_write;
            stage_q.memfwd_sel <= prep_i.memfwd_sel;
            stage_q.rd         <= prep_i.rd;
            stage_q.ld_reg     <= prep_i.ld_reg;
        end
    end

    // cache request stays primed across non-memory instructions
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_q.mem_addr <= '0;
            stage_q.byte_en  <= '0;
            stage_q.wdata    <= '0;
        end else if (req_ld) begin
            stage_q.mem_addr <= prep_i.mem_addr;
            stage_q.byte_en  <= prep_i.byte_en;
            stage_q.wdata    <= prep_i.wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (ex_mem_ld_i) begin
            valid_q <= 1'b1; // sticky until reset
        end
    end

    always_comb begin
        dmem_req_o.addr    = stage_q.mem_addr;
        dmem_req_o.wdata   = stage_q.wdata;
        dmem_req_o.byte_en = stage_q.byte_en;
        dmem_req_o.read    = stage_q.mem_read;
        dmem_req_o.write   = stage_q.mem_write;
    end

    assign stage_o        = stage_q;
    assign exe_fwd_data_o = stage_q.fwd_data;
    assign ex_mem_valid_o = valid_q;

endmodule : ex_mem_reg

// ==== src/ex_mem_prep.sv ====
module ex_mem_prep (
    input  pipe_pkg::ex_op_t  ex_op_i,
    output pipe_pkg::ex_mem_t prep_o
);
    import pipe_pkg::*;

    word_t                fwd_data;
    word_t                sel_addr;
    word_t                aligned_addr;
    logic [OFFSET_W-1:0]  offset;
    byte_en_t             byte_mask;
    byte_en_t             half_mask;
    byte_en_t             single_mask;
    logic                 do_align;

    always_comb begin
        case (ex_op_i.ctrl.exefwd_sel)
            exefwd_alu_out:    fwd_data = ex_op_i.alu_out;
            exefwd_br_en_zext: fwd_data = {{(XLEN-1){1'b0}}, ex_op_i.br_en};
            exefwd_u_imm:      fwd_data = ex_op_i.u_imm;
            default:           fwd_data = ex_op_i.alu_out;
        endcase
    end

    always_comb begin
        case (ex_op_i.ctrl.mar_sel)
            mar_pc_out:  sel_addr = ex_op_i.pc;
            mar_alu_out: sel_addr = ex_op_i.alu_out;
            default:     sel_addr = ex_op_i.alu_out;
        endcase
    end

    assign offset       = sel_addr[OFFSET_W-1:0];
    assign aligned_addr = {sel_addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign half_mask    = byte_en_t'(2'b11) << offset; // upper bits fall off
    assign single_mask  = byte_en_t'(1'b1) << offset;

    // loads win over stores when both are flagged
    always_comb begin
        byte_mask = '0;
        do_align  = 1'b0;
        if (ex_op_i.ctrl.mem_read) begin
            case (ex_op_i.ctrl.load_funct3)
                lw: begin
                    byte_mask = '1;
                end
                lh, lhu: begin
                    byte_mask = half_mask;
                    do_align  = 1'b1;
                end
                lb, lbu: begin
                    byte_mask = single_mask;
                    do_align  = 1'b1;
                end
                default: begin
                    byte_mask = '0; // undefined width
                end
            endcase
        end else if (ex_op_i.ctrl.mem_write) begin
            case (ex_op_i.ctrl.store_funct3)
                sw: begin
                    byte_mask = '1;
                end
                sh: begin
                    byte_mask = half_mask;
                    do_align  = 1'b1;
                end
                sb: begin
                    byte_mask = single_mask;
                    do_align  = 1'b1;
                end
                default: begin
                    byte_mask = '0;
                end
            endcase
        end
    end

    always_comb begin
        prep_o            = '0;
        prep_o.fwd_data   = fwd_data;
        prep_o.mem_addr   = do_align ? aligned_addr : sel_addr;
        prep_o.byte_en    = byte_mask;
        prep_o.wdata      = ex_op_i.rs2_data; // store data straight from rs2
        prep_o.mem_access = ex_op_i.ctrl.mem_read | ex_op_i.ctrl.mem_write;
        prep_o.mem_read   = ex_op_i.ctrl.mem_read;
        prep_o.mem_write  = ex_op_i.ctrl.mem_write;
        prep_o.memfwd_sel = ex_op_i.ctrl.memfwd_sel;
        prep_o.rd         = ex_op_i.ctrl.rd;
        prep_o.ld_reg     = ex_op_i.ctrl.ld_reg;
    end

endmodule : ex_mem_prep

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

    localparam int XLEN           = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int RF_ADDR_W      = 5;
    localparam int OFFSET_W       = $clog2(BYTES_PER_WORD); // byte offset within a word

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [RF_ADDR_W-1:0]      rf_addr_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // execute forward source
    typedef enum logic [1:0] {
        exefwd_alu_out    = 2'b00,
        exefwd_br_en_zext = 2'b01,
        exefwd_u_imm      = 2'b10
    } exefwd_sel_e;

    // memory address source
    typedef enum logic {
        mar_pc_out  = 1'b0,
        mar_alu_out = 1'b1
    } mar_sel_e;

    // memory forward source
    typedef enum logic {
        memfwd_mem_rdata = 1'b0,
        memfwd_exe_fwd   = 1'b1
    } memfwd_sel_e;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    typedef struct packed {
        exefwd_sel_e   exefwd_sel;
        mar_sel_e      mar_sel;
        memfwd_sel_e   memfwd_sel;
        logic          mem_read;
        logic          mem_write;
        load_funct3_e  load_funct3;
        store_funct3_e store_funct3;
        rf_addr_t      rd;
        logic          ld_reg;
    } mem_ctrl_t;

    typedef struct packed {
        word_t     alu_out;
        logic      br_en;
        word_t     u_imm;
        word_t     rs2_data;
        word_t     pc;
        mem_ctrl_t ctrl;
    } ex_op_t;

    typedef struct packed {
        word_t       fwd_data;
        word_t       mem_addr;
        byte_en_t    byte_en;
        word_t       wdata;
        logic        mem_access; // load or store
        logic        mem_read;
        logic        mem_write;
        memfwd_sel_e memfwd_sel;
        rf_addr_t    rd;
        logic        ld_reg;
    } ex_mem_t;

    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
        logic     read;
        logic     write;
    } dmem_req_t;

    typedef struct packed {
        rf_addr_t rd;
        logic     ld_reg;
    } wb_info_t;

endpackage : pipe_pkg
